// File: design/fp_format_pkg.sv
package fp_format_pkg;

    // IEEE 754 single-precision field widths
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;
    localparam int MAN_W  = 24;

    localparam int EXP_BIAS = 127;
    // All-ones exponent marks infinity and NaN
    localparam int EXP_MAX  = 255;

    // Guard, round and sticky
    localparam int GRS_W = 3;

    typedef logic [31:0]       fp_word_t;
    typedef logic [EXP_W-1:0]  fp_exp_t;
    typedef logic [FRAC_W-1:0] fp_frac_t;
    typedef logic [MAN_W-1:0]  fp_man_t;

    localparam fp_word_t QNAN = 32'h7FC0_0000;

    // Class mask bit positions in RISC-V order
    localparam int CLS_NEG_INF  = 0;
    localparam int CLS_NEG_NORM = 1;
    localparam int CLS_NEG_SUB  = 2;
    localparam int CLS_NEG_ZERO = 3;
    localparam int CLS_POS_ZERO = 4;
    localparam int CLS_POS_SUB  = 5;
    localparam int CLS_POS_NORM = 6;
    localparam int CLS_POS_INF  = 7;
    localparam int CLS_SNAN     = 8;
    localparam int CLS_QNAN     = 9;
    localparam int CLS_W        = 10;

endpackage

// File: design/fp_op_pkg.sv
package fp_op_pkg;

    // Operation codes on i_alu_ctrl
    typedef enum logic [4:0] {
        OP_FMUL     = 5'b01011,
        OP_FCVT_W_S = 5'b01100,
        OP_FCLASS   = 5'b01111
    } fp_op_e;

    // Saturation values for FCVT.W.S
    localparam logic [31:0] INT_MAX_W = 32'h7FFF_FFFF;
    localparam logic [31:0] INT_MIN_W = 32'h8000_0000;

endpackage

// File: design/fp_operand_if.sv
`timescale 1ns/1ps

interface fp_operand_if;
    import fp_format_pkg::*;

    logic    sign;
    fp_exp_t exp;
    // Significand with hidden bit
    fp_man_t man;
    logic    is_zero;
    logic    is_inf;
    logic    is_nan;
    logic    is_snan;

    modport dec (output sign, exp, man, is_zero, is_inf, is_nan, is_snan);
    modport unit (input sign, exp, man, is_zero, is_inf, is_nan, is_snan);

endinterface

// File: design/fp_operand_decode.sv
`timescale 1ns/1ps

module fp_operand_decode (
    input  fp_format_pkg::fp_word_t i_word,
    fp_operand_if.dec               o_op
);
    import fp_format_pkg::*;

    fp_exp_t  exp_w;
    fp_frac_t frac_w;
    logic     exp_zero;
    logic     exp_ones;
    logic     frac_zero;
    logic     nan_w;

    assign exp_w     = i_word[FRAC_W +: EXP_W];
    assign frac_w    = i_word[FRAC_W-1:0];
    assign exp_zero  = (exp_w == '0);
    assign exp_ones  = (exp_w == fp_exp_t'(EXP_MAX));
    assign frac_zero = (frac_w == '0);
    assign nan_w     = exp_ones && !frac_zero;

    assign o_op.sign    = i_word[EXP_W+FRAC_W];
    assign o_op.exp     = exp_w;
    // Hidden bit only for nonzero exponents
    assign o_op.man     = {!exp_zero, frac_w};
    assign o_op.is_zero = exp_zero && frac_zero;
    assign o_op.is_inf  = exp_ones && frac_zero;
    assign o_op.is_nan  = nan_w;
    // Quiet bit is the top fraction bit
    assign o_op.is_snan = nan_w && !frac_w[FRAC_W-1];

endmodule

// File: design/fp_round_rne.sv
`timescale 1ns/1ps

module fp_round_rne #(
    parameter int WIDTH = 23
) (
    input  logic [WIDTH-1:0] i_value,
    input  logic             i_guard,
    input  logic             i_round,
    input  logic             i_sticky,
    output logic [WIDTH-1:0] o_value,
    output logic             o_carry
);

    logic           round_up;
    logic [WIDTH:0] sum;

    // Above half rounds up, exact half rounds to even
    assign round_up = i_guard && (i_round || i_sticky || i_value[0]);

    assign sum     = {1'b0, i_value} + {{WIDTH{1'b0}}, round_up};
    assign o_value = sum[WIDTH-1:0];
    assign o_carry = sum[WIDTH];

endmodule

// File: design/fp_mul.sv
`timescale 1ns/1ps

module fp_mul (
    fp_operand_if.unit               i_op_a,
    fp_operand_if.unit               i_op_b,
    output fp_format_pkg::fp_word_t  o_result,
    output logic                     o_invalid
);
    import fp_format_pkg::*;

    localparam int PROD_W = 2 * MAN_W;
    // Exponent arithmetic needs headroom for sum and sign
    localparam int XW     = EXP_W + 2;

    logic [PROD_W-1:0]    product;
    logic                 prod_top;
    fp_frac_t             frac_norm;
    logic [GRS_W-1:0]     grs;
    fp_frac_t             frac_rnd;
    logic                 rnd_carry;
    logic signed [XW-1:0] exp_unrnd;
    logic signed [XW-1:0] exp_final;
    logic                 sign_res;
    fp_word_t             result_w;

    assign sign_res = i_op_a.sign ^ i_op_b.sign;
    assign product  = i_op_a.man * i_op_b.man;
    assign prod_top = product[PROD_W-1];

    // Normalize on the product's top bit
    always_comb begin
        if (prod_top) begin
            frac_norm = product[PROD_W-2 -: FRAC_W];
            grs = {product[PROD_W-MAN_W-1], product[PROD_W-MAN_W-2],
                   |product[PROD_W-MAN_W-3:0]};
        end else begin
            frac_norm = product[PROD_W-3 -: FRAC_W];
            grs = {product[PROD_W-MAN_W-2], product[PROD_W-MAN_W-3],
                   |product[PROD_W-MAN_W-4:0]};
        end
    end

    fp_round_rne #(
        .WIDTH (FRAC_W)
    ) round_inst (
        .i_value  (frac_norm),
        .i_guard  (grs[GRS_W-1]),
        .i_round  (grs[GRS_W-2]),
        .i_sticky (grs[0]),
        .o_value  (frac_rnd),
        .o_carry  (rnd_carry)
    );

    assign exp_unrnd = $signed({2'b00, i_op_a.exp}) + $signed({2'b00, i_op_b.exp})
                     - XW'(EXP_BIAS) + $signed({{(XW-1){1'b0}}, prod_top});
    // Rounding carry leaves fraction zero and bumps the exponent
    assign exp_final = exp_unrnd + $signed({{(XW-1){1'b0}}, rnd_carry});

    always_comb begin
        o_invalid = 1'b0;
        result_w  = {sign_res, exp_final[EXP_W-1:0], frac_rnd};
        if (i_op_a.is_inf || i_op_a.is_nan || i_op_b.is_inf || i_op_b.is_nan) begin
            result_w  = QNAN;
            o_invalid = 1'b1;
        end else if (i_op_a.is_zero || i_op_b.is_zero) begin
            result_w = '0;
        end else if (exp_final >= EXP_MAX) begin
            // Overflow to signed infinity
            result_w  = {sign_res, fp_exp_t'(EXP_MAX), {FRAC_W{1'b0}}};
            o_invalid = 1'b1;
        end else if (exp_final <= 0) begin
            result_w  = '0;
            o_invalid = 1'b1;
        end
    end

    // Zero magnitude is always +0
    assign o_result = (result_w[EXP_W+FRAC_W-1:0] == '0) ? '0 : result_w;

endmodule

// File: design/fp_cvt_ws.sv
`timescale 1ns/1ps

module fp_cvt_ws (
    fp_operand_if.unit         i_op_a,
    output logic signed [31:0] o_result,
    output logic               o_invalid
);
    import fp_format_pkg::*;
    import fp_op_pkg::*;

    localparam int INT_W = 32;
    // Fraction bits kept below the binary point
    localparam int FRC_W = MAN_W + 1;
    localparam int FIX_W = INT_W + FRC_W;
    localparam int SH_W  = $clog2(FIX_W);
    localparam int XW    = EXP_W + 2;

    logic signed [XW-1:0] exp_unb;
    logic [SH_W-1:0]      shift_amt;
    logic [FIX_W-1:0]     fixed;
    logic [INT_W-1:0]     mag_rnd;
    logic                 rnd_carry;

    assign exp_unb = $signed({2'b00, i_op_a.exp}) - XW'(EXP_BIAS);

    // Exponent 31 goes through the shifter so -2^31 converts exactly
    assign shift_amt = SH_W'(INT_W - 1 - exp_unb);
    assign fixed     = {i_op_a.man, {(FIX_W-MAN_W){1'b0}}} >> shift_amt;

    fp_round_rne #(
        .WIDTH (INT_W)
    ) round_inst (
        .i_value  (fixed[FIX_W-1 -: INT_W]),
        .i_guard  (fixed[FRC_W-1]),
        .i_round  (fixed[FRC_W-2]),
        .i_sticky (|fixed[FRC_W-3:0]),
        .o_value  (mag_rnd),
        .o_carry  (rnd_carry)
    );

    always_comb begin
        o_invalid = 1'b0;
        o_result  = '0;
        if (i_op_a.is_nan) begin
            o_result  = INT_MAX_W;
            o_invalid = 1'b1;
        end else if (i_op_a.is_inf || exp_unb > INT_W - 1) begin
            o_result  = i_op_a.sign ? INT_MIN_W : INT_MAX_W;
            o_invalid = 1'b1;
        end else if (exp_unb < -1) begin
            // Magnitude below one half
            o_result = '0;
        end else if (i_op_a.sign) begin
            if (rnd_carry || mag_rnd > INT_MIN_W) begin
                o_result  = INT_MIN_W;
                o_invalid = 1'b1;
            end else begin
                o_result = -mag_rnd;
            end
        end else begin
            if (rnd_carry || mag_rnd[INT_W-1]) begin
                o_result  = INT_MAX_W;
                o_invalid = 1'b1;
            end else begin
                o_result = mag_rnd;
            end
        end
    end

endmodule

// File: design/fp_classify.sv
`timescale 1ns/1ps

module fp_classify (
    fp_operand_if.unit                           i_op_a,
    output logic [fp_format_pkg::CLS_W-1:0]      o_result
);
    import fp_format_pkg::*;

    logic is_sub;

    // Zero exponent with nonzero fraction
    assign is_sub = (i_op_a.exp == '0) && !i_op_a.is_zero;

    always_comb begin
        o_result = '0;
        if (i_op_a.is_nan) begin
            if (i_op_a.is_snan) begin
                o_result[CLS_SNAN] = 1'b1;
            end else begin
                o_result[CLS_QNAN] = 1'b1;
            end
        end else if (i_op_a.is_inf) begin
            o_result[i_op_a.sign ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
        end else if (i_op_a.is_zero) begin
            o_result[i_op_a.sign ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
        end else if (is_sub) begin
            o_result[i_op_a.sign ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
        end else begin
            o_result[i_op_a.sign ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
        end
    end

endmodule

// File: design/fp_unit.sv
`timescale 1ns/1ps

module fp_unit (
    input  fp_format_pkg::fp_word_t i_data_r1,
    input  fp_format_pkg::fp_word_t i_data_r2,
    input  logic [4:0]              i_alu_ctrl,
    output fp_format_pkg::fp_word_t o_data,
    output logic                    o_invalid
);
    import fp_format_pkg::*;
    import fp_op_pkg::*;

    fp_word_t           mul_result;
    logic               mul_invalid;
    logic signed [31:0] cvt_result;
    logic               cvt_invalid;
    logic [CLS_W-1:0]   cls_result;

    fp_operand_if op_a ();
    fp_operand_if op_b ();

    fp_operand_decode dec_a_inst (.i_word(i_data_r1), .o_op(op_a));
    fp_operand_decode dec_b_inst (.i_word(i_data_r2), .o_op(op_b));

    // All three units see the decoded operands at once
    fp_mul mul_inst (
        .i_op_a    (op_a),
        .i_op_b    (op_b),
        .o_result  (mul_result),
        .o_invalid (mul_invalid)
    );

    fp_cvt_ws cvt_inst (.i_op_a(op_a), .o_result(cvt_result), .o_invalid(cvt_invalid));

    fp_classify cls_inst (.i_op_a(op_a), .o_result(cls_result));

    always_comb begin
        case (i_alu_ctrl)
            OP_FMUL: begin
                o_data    = mul_result;
                o_invalid = mul_invalid;
            end
            OP_FCVT_W_S: begin
                o_data    = cvt_result;
                o_invalid = cvt_invalid;
            end
            OP_FCLASS: begin
                o_data    = {{($bits(fp_word_t)-CLS_W){1'b0}}, cls_result};
                o_invalid = 1'b0;
            end
            // Any other code drives zero data and zero invalid
            default: begin
                o_data    = '0;
                o_invalid = 1'b0;
            end
        endcase
    end

endmodule

// File: dv/fp_unit_asserts.sv
`timescale 1ns/1ps

module fp_unit_asserts (
    input logic                    i_clk,
    input logic [4:0]              i_alu_ctrl,
    input fp_format_pkg::fp_word_t i_data,
    input logic                    i_invalid
);
    import fp_format_pkg::*;
    import fp_op_pkg::*;

    logic op_used;

    assign op_used = (i_alu_ctrl == OP_FMUL) || (i_alu_ctrl == OP_FCVT_W_S)
                  || (i_alu_ctrl == OP_FCLASS);

    // Unused codes drive zero on both outputs
    a_unused_zero: assert property (@(posedge i_clk)
        !op_used |-> (i_data == '0) && !i_invalid)
        else $error("unused operation code gave nonzero data or invalid");

    // Exactly one class bit and nothing above the mask
    a_class_onehot: assert property (@(posedge i_clk)
        (i_alu_ctrl == OP_FCLASS) |-> !i_invalid && $onehot(i_data[CLS_W-1:0])
                                      && (i_data[31:CLS_W] == '0))
        else $error("classify result is not a single mask bit with invalid low");

    a_cvt_saturate: assert property (@(posedge i_clk)
        (i_alu_ctrl == OP_FCVT_W_S) && i_invalid |-> (i_data == INT_MAX_W)
                                                     || (i_data == INT_MIN_W))
        else $error("invalid conversion did not give a saturation value");

endmodule

// File: dv/tb_fp_unit.sv
`timescale 1ns/1ps

module tb_fp_unit;
    import fp_format_pkg::*;
    import fp_op_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    // One word per class, in mask bit order
    localparam fp_word_t CLASS_WORDS [CLS_W] = '{
        32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000, 32'h0000_0000,
        32'h0040_0000, 32'h3F80_0000, 32'h7F80_0000, 32'h7F80_0001, 32'h7FC0_0000
    };

    logic        clk;
    logic        i_arst_n;
    fp_word_t    i_data_r1;
    fp_word_t    i_data_r2;
    logic [4:0]  i_alu_ctrl;
    fp_word_t    o_data;
    logic        o_invalid;
    logic [31:0] lfsr_state = 32'hb32;
    logic        drv_valid = 1'b0;
    logic        stim_done = 1'b0;
    string       drv_name;
    int          checked_count;
    logic [4:0]  vec_op[$];
    fp_word_t    vec_a[$];
    fp_word_t    vec_b[$];
    string       vec_name[$];

    fp_unit fp_unit_inst (
        .i_data_r1  (i_data_r1),
        .i_data_r2  (i_data_r2),
        .i_alu_ctrl (i_alu_ctrl),
        .o_data     (o_data),
        .o_invalid  (o_invalid)
    );

    bind fp_unit fp_unit_asserts asserts_inst (
        .i_clk      (tb_fp_unit.clk),
        .i_alu_ctrl (i_alu_ctrl),
        .i_data     (o_data),
        .i_invalid  (o_invalid)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
            r = {r[30:0], b};
        end
        return r;
    endfunction

    // Random sign and fraction, exponent from exp_lo up by exp_bits random bits
    function automatic fp_word_t rand_float(input int exp_lo, input int exp_bits);
        logic     sign;
        fp_exp_t  exp;
        fp_frac_t frac;
        sign = 1'(rand_bits(1));
        exp  = fp_exp_t'(exp_lo + int'(rand_bits(exp_bits)));
        frac = fp_frac_t'(rand_bits(FRAC_W));
        return {sign, exp, frac};
    endfunction

    // Integer part of v / 2**sh, rounded to nearest even
    function automatic longint shift_round(input longint v, input int sh);
        longint keep;
        longint rem;
        longint half;
        if (sh <= 0) begin
            return v << -sh;
        end
        keep = v >> sh;
        rem  = v - (keep << sh);
        half = longint'(1) << (sh - 1);
        if (rem > half || (rem == half && keep[0])) begin
            keep = keep + 1;
        end
        return keep;
    endfunction

    // Expected {invalid, data} for one operation
    function automatic logic [32:0] fp_ref(input logic [4:0] op, input fp_word_t a,
                                           input fp_word_t b);
        int     ea;
        int     eb;
        int     e;
        int     pos;
        longint ma;
        longint mb;
        longint mag;
        ea = a[30:23];
        eb = b[30:23];
        ma = {1'b1, a[22:0]};
        mb = {1'b1, b[22:0]};
        case (op)
            OP_FMUL: begin
                if (ea == EXP_MAX || eb == EXP_MAX) begin
                    return {1'b1, QNAN};
                end
                if (a[30:0] == '0 || b[30:0] == '0) begin
                    return '0;
                end
                mag = ma * mb;
                e   = ea + eb - EXP_BIAS;
                // Product of two significands lies in [1, 4)
                if (mag >= (longint'(1) << 47)) begin
                    e   = e + 1;
                    mag = shift_round(mag, 24);
                end else begin
                    mag = shift_round(mag, 23);
                end
                if (mag == (longint'(1) << MAN_W)) begin
                    e   = e + 1;
                    mag = mag >> 1;
                end
                if (e >= EXP_MAX) begin
                    return {1'b1, a[31] ^ b[31], 8'hFF, 23'd0};
                end
                if (e <= 0) begin
                    return {1'b1, 32'd0};
                end
                return {1'b0, a[31] ^ b[31], e[7:0], mag[22:0]};
            end
            OP_FCVT_W_S: begin
                e = ea - EXP_BIAS;
                if (ea == EXP_MAX && a[22:0] != '0) begin
                    return {1'b1, INT_MAX_W};
                end
                // Exponent 31 goes to the range check, where -2**31 is exact
                if (ea == EXP_MAX || e > 31) begin
                    return {1'b1, a[31] ? INT_MIN_W : INT_MAX_W};
                end
                if (e < -1) begin
                    return '0;
                end
                mag = shift_round(ma, FRAC_W - e);
                if (a[31] && mag > (longint'(1) << 31)) begin
                    return {1'b1, INT_MIN_W};
                end
                if (!a[31] && mag >= (longint'(1) << 31)) begin
                    return {1'b1, INT_MAX_W};
                end
                mag = a[31] ? -mag : mag;
                return {1'b0, mag[31:0]};
            end
            OP_FCLASS: begin
                if (ea == EXP_MAX && a[22:0] != '0) begin
                    pos = a[22] ? CLS_QNAN : CLS_SNAN;
                end else if (ea == EXP_MAX) begin
                    pos = a[31] ? CLS_NEG_INF : CLS_POS_INF;
                end else if (ea == 0 && a[22:0] == '0) begin
                    pos = a[31] ? CLS_NEG_ZERO : CLS_POS_ZERO;
                end else if (ea == 0) begin
                    pos = a[31] ? CLS_NEG_SUB : CLS_POS_SUB;
                end else begin
                    pos = a[31] ? CLS_NEG_NORM : CLS_POS_NORM;
                end
                return {1'b0, 32'd1 << pos};
            end
            default: begin
                return '0;
            end
        endcase
    endfunction

    task automatic add_vec(input string name, input logic [4:0] op, input fp_word_t a,
                           input fp_word_t b);
        vec_name.push_back(name);
        vec_op.push_back(op);
        vec_a.push_back(a);
        vec_b.push_back(b);
    endtask

    task automatic build_vectors();
        fp_word_t   a;
        fp_word_t   b;
        logic [4:0] unused_codes [4] = '{5'b01010, 5'b00000, 5'b11111, 5'b01101};
        // Exact half ulp, once with an odd and once with an even lsb
        add_vec("mul_tie_odd", OP_FMUL, 32'h3F80_0001, 32'h3FC0_0000);
        add_vec("mul_tie_even", OP_FMUL, 32'h3F80_0003, 32'h3FC0_0000);
        add_vec("mul_zero", OP_FMUL, 32'h8000_0000, 32'h4049_0FDB);
        add_vec("mul_inf", OP_FMUL, 32'h3F80_0000, 32'hFF80_0000);
        add_vec("mul_nan", OP_FMUL, 32'h7FC0_0000, 32'h4000_0000);
        add_vec("mul_inf_zero", OP_FMUL, 32'h7F80_0000, 32'h0000_0000);
        add_vec("mul_ovf_pos", OP_FMUL, 32'h7F00_0000, 32'h7F00_0000);
        add_vec("mul_ovf_neg", OP_FMUL, 32'hFF00_0000, 32'h7F00_0000);
        add_vec("mul_unf", OP_FMUL, 32'h0800_0000, 32'h8800_0000);
        for (int i = 0; i < 40; i++) begin
            a = rand_float(90, 6);
            b = rand_float(90, 6);
            add_vec($sformatf("mul_rand_%0d", i), OP_FMUL, a, b);
        end
        add_vec("cvt_0.5", OP_FCVT_W_S, 32'h3F00_0000, '0);
        add_vec("cvt_1.5", OP_FCVT_W_S, 32'h3FC0_0000, '0);
        add_vec("cvt_2.5", OP_FCVT_W_S, 32'h4020_0000, '0);
        add_vec("cvt_-2.5", OP_FCVT_W_S, 32'hC020_0000, '0);
        add_vec("cvt_0.4", OP_FCVT_W_S, 32'h3ECC_CCCD, '0);
        add_vec("cvt_qnan", OP_FCVT_W_S, 32'h7FC0_0000, '0);
        add_vec("cvt_snan", OP_FCVT_W_S, 32'hFF80_0001, '0);
        add_vec("cvt_pos_inf", OP_FCVT_W_S, 32'h7F80_0000, '0);
        add_vec("cvt_neg_inf", OP_FCVT_W_S, 32'hFF80_0000, '0);
        add_vec("cvt_2^31", OP_FCVT_W_S, 32'h4F00_0000, '0);
        add_vec("cvt_-2^31", OP_FCVT_W_S, 32'hCF00_0000, '0);
        add_vec("cvt_below_-2^31", OP_FCVT_W_S, 32'hCF00_0001, '0);
        add_vec("cvt_2^63", OP_FCVT_W_S, 32'h5F00_0000, '0);
        for (int i = 0; i < 30; i++) begin
            add_vec($sformatf("cvt_rand_%0d", i), OP_FCVT_W_S, rand_float(126, 5), '0);
        end
        for (int i = 0; i < 10; i++) begin
            add_vec($sformatf("cvt_tiny_%0d", i), OP_FCVT_W_S, rand_float(0, 6), '0);
        end
        foreach (CLASS_WORDS[i]) begin
            add_vec($sformatf("fclass_bit_%0d", i), OP_FCLASS, CLASS_WORDS[i], '0);
        end
        for (int i = 0; i < 16; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            add_vec($sformatf("unused_%0d", i), unused_codes[i % 4], a, b);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // Values are {invalid, data}
    task automatic check_equal(input string name, input logic [32:0] expected,
                               input logic [32:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("mismatch %s expected data %h invalid %b actual data %h invalid %b",
                               name, expected[31:0], expected[32], actual[31:0], actual[32]));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Stimulus 2 ns after each rising edge
    initial begin
        i_arst_n   = 1'b0;
        i_data_r1  = '0;
        i_data_r2  = '0;
        i_alu_ctrl = '0;
        drv_name   = "";
        build_vectors();
        repeat (3) @(posedge clk);
        #2 i_arst_n = 1'b1;
        foreach (vec_op[i]) begin
            @(posedge clk);
            #2;
            i_alu_ctrl = vec_op[i];
            i_data_r1  = vec_a[i];
            i_data_r2  = vec_b[i];
            drv_name   = vec_name[i];
            drv_valid  = i_arst_n;
        end
        @(posedge clk);
        #2;
        drv_valid = 1'b0;
        stim_done = 1'b1;
    end

    // Compare just before the next rising edge
    initial begin
        int          cycles;
        logic [32:0] expected;
        checked_count = 0;
        cycles = 0;
        while (!stim_done) begin
            @(posedge clk);
            #18;
            if (drv_valid) begin
                expected = fp_ref(i_alu_ctrl, i_data_r1, i_data_r2);
                check_equal(drv_name, expected, {o_invalid, o_data});
                checked_count++;
            end
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_run($sformatf("stimulus did not finish within %0d cycles", TIMEOUT_CYCLES));
            end
        end
        if (checked_count > 0 && checked_count == vec_op.size()) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_run($sformatf("only %0d of %0d vectors were checked",
                               checked_count, vec_op.size()));
        end
    end

endmodule

// File: tb.f
design/fp_format_pkg.sv
design/fp_op_pkg.sv
design/fp_operand_if.sv
design/fp_operand_decode.sv
design/fp_round_rne.sv
design/fp_mul.sv
design/fp_cvt_ws.sv
design/fp_classify.sv
design/fp_unit.sv
dv/fp_unit_asserts.sv
dv/tb_fp_unit.sv
